// File: fv_bank_settings.svh
`ifndef FV_BANK_SETTINGS_SVH
`define FV_BANK_SETTINGS_SVH

// line geometry.
`define FV_LINE_W     64
`define FV_PER_LINE   4

// bank size in lines.
`define FV_BANK_DEPTH 256

// largest feature count of a single read request.
`define FV_MAX_NUM    32

// number of edge processing elements behind the bank.
`define FV_NUM_PE     8

// request queue entries, equal to the credits held after reset.
`define FV_REQ_DEPTH  4

`endif

// File: fv_bank_pkg.sv
`default_nettype none

`include "fv_bank_settings.svh"

package fv_bank_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`FV_LINE_W-1:0] fv_line_t;
    typedef logic [$clog2(`FV_BANK_DEPTH)-1:0] fv_addr_t;

    // one extra bit so the full FV_MAX_NUM fits.
    typedef logic [$clog2(`FV_MAX_NUM):0] fv_count_t;
    typedef logic [$clog2(`FV_NUM_PE)-1:0] pe_tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_WRITE  = 2'd1,
        ST_STREAM = 2'd2
    } bank_state_t;

endpackage

`default_nettype wire

// File: fv_sram_if.sv
`timescale 1ns/100ps
`default_nettype none

// one single-port SRAM port, chip and write enables active low.
interface fv_sram_if;
    import fv_bank_pkg::*;

    logic     cen;
    logic     wen;
    fv_addr_t a;
    fv_line_t d;
    fv_line_t q;

    modport controller (
        output cen, wen, a, d,
        input  q
    );

    // q holds the last read until the next read.
    modport memory (
        input  cen, wen, a, d,
        output q
    );

endinterface

`default_nettype wire

// File: fv_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// head entry of the request queue, pop strobes back from the controller.
interface fv_req_if;
    import fv_bank_pkg::*;

    logic      valid;
    fv_addr_t  addr;
    fv_count_t num_fv;
    pe_tag_t   tag;
    logic      pop;

    modport queue (
        output valid, addr, num_fv, tag,
        input  pop
    );

    // pop is a single-cycle accept, only while valid.
    modport controller (
        input  valid, addr, num_fv, tag,
        output pop
    );

endinterface

`default_nettype wire

// File: fv_req_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "fv_bank_settings.svh"

module fv_req_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  fv_bank_pkg::fv_addr_t  req_addr,
    input  fv_bank_pkg::fv_count_t req_num_fv,
    input  fv_bank_pkg::pe_tag_t   req_tag,
    output logic                   req_credit,
    fv_req_if.queue                head
);
    import fv_bank_pkg::*;

    localparam int DEPTH = `FV_REQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fv_addr_t         addr_mem [DEPTH];
    fv_count_t        num_mem  [DEPTH];
    pe_tag_t          tag_mem  [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // entry storage.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            addr_mem[wr_ptr] <= req_addr;
            num_mem[wr_ptr]  <= req_num_fv;
            tag_mem[wr_ptr]  <= req_tag;
        end
    end

    // the credit rule keeps pushes away from a full queue.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (head.pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({req_valid, head.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per accepted request.
            req_credit <= head.pop;
        end
    end

    assign head.valid  = (count != '0);
    assign head.addr   = addr_mem[rd_ptr];
    assign head.num_fv = num_mem[rd_ptr];
    assign head.tag    = tag_mem[rd_ptr];

endmodule

`default_nettype wire

// File: fv_bank_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fv_bank_settings.svh"

module fv_bank_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_sos,
    input  logic                   wr_eos,
    input  fv_bank_pkg::fv_addr_t  wr_addr,
    input  fv_bank_pkg::fv_line_t  wr_data,
    fv_req_if.controller           req,
    fv_sram_if.controller          mem,
    output logic                   out_valid,
    output logic                   out_sos,
    output logic                   out_eos,
    output fv_bank_pkg::pe_tag_t   out_tag,
    output fv_bank_pkg::fv_line_t  out_data,
    output logic                   busy
);
    import fv_bank_pkg::*;

    localparam int SUM_W = $bits(fv_count_t) + 1;

    bank_state_t      state;
    bank_state_t      nx_state;
    fv_addr_t         addr_q;
    fv_addr_t         nx_addr;
    fv_addr_t         step_addr;
    fv_count_t        lines_left;
    fv_count_t        nx_left;
    pe_tag_t          tag_q;
    pe_tag_t          nx_tag;
    logic [SUM_W-1:0] lines_sum;
    fv_count_t        req_lines;

    // read issue flags for the beat addressed this cycle.
    logic    rd_issue;
    logic    rd_sos;
    logic    rd_eos;
    pe_tag_t rd_tag;

    // first flag stage, in step with the SRAM read.
    logic    s1_valid;
    logic    s1_sos;
    logic    s1_eos;
    pe_tag_t s1_tag;

    // lines covering the request, rounded up.
    assign lines_sum = {1'b0, req.num_fv} + SUM_W'(`FV_PER_LINE - 1);
    assign req_lines = fv_count_t'(lines_sum / `FV_PER_LINE);
    assign step_addr = addr_q + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state and SRAM port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        nx_state = state;
        nx_addr  = addr_q;
        nx_left  = lines_left;
        nx_tag   = tag_q;
        mem.cen  = 1'b1;
        mem.wen  = 1'b1;
        mem.a    = addr_q;
        mem.d    = wr_data;
        req.pop  = 1'b0;
        rd_issue = 1'b0;
        rd_sos   = 1'b0;
        rd_eos   = 1'b0;
        rd_tag   = tag_q;
        busy     = 1'b0;
        case (state)
            ST_IDLE: begin
                if (wr_sos) begin
                    // loader wins over a waiting request.
                    mem.cen = 1'b0;
                    mem.wen = 1'b0;
                    mem.a   = wr_addr;
                    if (!wr_eos) begin
                        nx_state = ST_WRITE;
                    end
                end else if (req.valid) begin
                    req.pop  = 1'b1;
                    mem.cen  = 1'b0;
                    mem.a    = req.addr;
                    nx_addr  = req.addr;
                    nx_tag   = req.tag;
                    rd_issue = 1'b1;
                    rd_sos   = 1'b1;
                    rd_tag   = req.tag;
                    if (req_lines > fv_count_t'(1)) begin
                        nx_state = ST_STREAM;
                        nx_left  = req_lines - 1'b1;
                    end else begin
                        rd_eos = 1'b1;
                    end
                end
            end
            ST_WRITE: begin
                busy    = 1'b1;
                mem.cen = 1'b0;
                mem.wen = 1'b0;
                mem.a   = wr_addr;
                if (wr_eos) begin
                    nx_state = ST_IDLE;
                end
            end
            ST_STREAM: begin
                mem.cen  = 1'b0;
                mem.a    = step_addr;
                nx_addr  = step_addr;
                nx_left  = lines_left - 1'b1;
                rd_issue = 1'b1;
                if (lines_left == fv_count_t'(1)) begin
                    // last address, busy drops already.
                    nx_state = ST_IDLE;
                    rd_eos   = 1'b1;
                end else begin
                    busy = 1'b1;
                end
            end
            default: begin
                nx_state = ST_IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers and beat pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            addr_q     <= '0;
            lines_left <= '0;
            s1_valid   <= 1'b0;
            s1_sos     <= 1'b0;
            s1_eos     <= 1'b0;
            out_valid  <= 1'b0;
            out_sos    <= 1'b0;
            out_eos    <= 1'b0;
        end else begin
            state      <= nx_state;
            addr_q     <= nx_addr;
            lines_left <= nx_left;
            s1_valid   <= rd_issue;
            s1_sos     <= rd_sos;
            s1_eos     <= rd_eos;
            out_valid  <= s1_valid;
            out_sos    <= s1_sos;
            out_eos    <= s1_eos;
        end
    end

    // tag and data travel without reset.
    always_ff @(posedge clk) begin
        tag_q    <= nx_tag;
        s1_tag   <= rd_tag;
        out_tag  <= s1_tag;
        out_data <= mem.q;
    end

endmodule

`default_nettype wire

// File: fv_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "fv_bank_settings.svh"

module fv_sram (
    input logic       clk,
    fv_sram_if.memory port
);
    import fv_bank_pkg::*;

    fv_line_t mem [`FV_BANK_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // single port, one access per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write on cen and wen low.
    always_ff @(posedge clk) begin
        if (!port.cen && !port.wen) begin
            mem[port.a] <= port.d;
        end
    end

    // read data shows up the cycle after the address.
    // q keeps its value across idle and write cycles.
    always_ff @(posedge clk) begin
        if (!port.cen && port.wen) begin
            port.q <= mem[port.a];
        end
    end

endmodule

`default_nettype wire

// File: fv_bank_top.sv
`timescale 1ns/100ps
`default_nettype none

module fv_bank_top (
    input  logic                   clk,
    input  logic                   reset,
    // loader bursts.
    input  logic                   wr_sos,
    input  logic                   wr_eos,
    input  fv_bank_pkg::fv_addr_t  wr_addr,
    input  fv_bank_pkg::fv_line_t  wr_data,
    // read requests under credit flow.
    input  logic                   req_valid,
    input  fv_bank_pkg::fv_addr_t  req_addr,
    input  fv_bank_pkg::fv_count_t req_num_fv,
    input  fv_bank_pkg::pe_tag_t   req_tag,
    output logic                   req_credit,
    // stream to the edge processing elements.
    output logic                   out_valid,
    output logic                   out_sos,
    output logic                   out_eos,
    output fv_bank_pkg::pe_tag_t   out_tag,
    output fv_bank_pkg::fv_line_t  out_data,
    output logic                   busy
);

    fv_req_if  req_bus ();
    fv_sram_if sram_bus ();

    fv_req_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_num_fv (req_num_fv),
        .req_tag    (req_tag),
        .req_credit (req_credit),
        .head       (req_bus.queue)
    );

    fv_bank_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .wr_sos    (wr_sos),
        .wr_eos    (wr_eos),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .req       (req_bus.controller),
        .mem       (sram_bus.controller),
        .out_valid (out_valid),
        .out_sos   (out_sos),
        .out_eos   (out_eos),
        .out_tag   (out_tag),
        .out_data  (out_data),
        .busy      (busy)
    );

    fv_sram u_sram (
        .clk  (clk),
        .port (sram_bus.memory)
    );

endmodule

`default_nettype wire

// File: fv_bank_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fv_bank_chk (
    input logic clk,
    input logic reset,
    input logic wr_sos,
    input logic pop,
    input logic req_credit,
    input logic out_valid,
    input logic out_sos,
    input logic out_eos,
    input logic busy
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stream and credit port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_flags_need_valid: assert property (@(posedge clk) disable iff (reset)
        (out_sos || out_eos) |-> out_valid)
        else $error("sos or eos without out_valid");

    // one credit for each popped request, a cycle later.
    a_credit_after_pop: assert property (@(posedge clk) disable iff (reset)
        req_credit |-> $past(pop))
        else $error("credit returned without a pop the cycle before");

    a_write_when_idle: assert property (@(posedge clk) disable iff (reset)
        wr_sos |-> !busy)
        else $error("write start while the bank is busy");

    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!busy && !out_valid))
        else $error("busy or out_valid high after reset");

endmodule

`default_nettype wire

// File: fv_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fv_bank_settings.svh"

module fv_bank_tb;
    import fv_bank_pkg::*;

    localparam int MAX_LINES = `FV_MAX_NUM / `FV_PER_LINE;
    localparam int TIMEOUT   = 2000;

    typedef fv_line_t beat_list_t [MAX_LINES];

    logic      clk;
    logic      reset;
    logic      wr_sos;
    logic      wr_eos;
    fv_addr_t  wr_addr;
    fv_line_t  wr_data;
    logic      req_valid;
    fv_addr_t  req_addr;
    fv_count_t req_num_fv;
    pe_tag_t   req_tag;
    logic      req_credit;
    logic      out_valid;
    logic      out_sos;
    logic      out_eos;
    pe_tag_t   out_tag;
    fv_line_t  out_data;
    logic      busy;

    fv_line_t   shadow [`FV_BANK_DEPTH];
    fv_addr_t   pend_addr [$];
    fv_count_t  pend_num [$];
    pe_tag_t    pend_tag [$];
    beat_list_t exp_lines;
    int         exp_count;
    int         beat_idx;
    fv_addr_t   cur_addr;
    fv_count_t  cur_num;
    pe_tag_t    cur_tag;
    int         credits;
    int         errors;
    string      test_name;

    fv_bank_top dut0 (.*);

    bind fv_bank_top fv_bank_chk chk0 (
        .clk        (clk),
        .reset      (reset),
        .wr_sos     (wr_sos),
        .pop        (req_bus.pop),
        .req_credit (req_credit),
        .out_valid  (out_valid),
        .out_sos    (out_sos),
        .out_eos    (out_eos),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_failure();
        errors++;
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input string name, input fv_line_t exp, input fv_line_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_tag(input string name, input pe_tag_t exp, input pe_tag_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input fv_count_t exp, input fv_count_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    // one beat per covering line, read from the shadow copy.
    function automatic int expect_beats(input fv_addr_t base, input fv_count_t num,
                                        output beat_list_t lines);
        int n;
        n = (int'(num) + `FV_PER_LINE - 1) / `FV_PER_LINE;
        for (int k = 0; k < MAX_LINES; k++) begin
            lines[k] = (k < n) ? shadow[fv_addr_t'(base + k)] : '0;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        if (!reset && req_credit === 1'b1) begin
            credits++;
            if (credits > `FV_REQ_DEPTH) begin
                $display("more credits returned than the queue holds in %s", test_name);
                report_failure();
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && out_valid === 1'b1) begin
            if (beat_idx == 0 && pend_addr.size() == 0) begin
                $display("output beat arrived with no request outstanding in %s", test_name);
                report_failure();
            end else begin
                if (beat_idx == 0) begin
                    cur_addr  = pend_addr.pop_front();
                    cur_num   = pend_num.pop_front();
                    cur_tag   = pend_tag.pop_front();
                    exp_count = expect_beats(cur_addr, cur_num, exp_lines);
                end
                check_flag({test_name, " sos"}, beat_idx == 0, out_sos);
                check_flag({test_name, " eos"}, beat_idx == exp_count - 1, out_eos);
                check_tag({test_name, " tag"}, cur_tag, out_tag);
                check_line({test_name, " data"}, exp_lines[beat_idx], out_data);
                beat_idx = (beat_idx + 1 == exp_count) ? 0 : beat_idx + 1;
            end
        end else if (!reset && beat_idx != 0) begin
            $display("stream broke off after %0d of %0d beats in %s",
                     beat_idx, exp_count, test_name);
            report_failure();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus, all driven on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_credit();
        int waited;
        waited = 0;
        while (credits == 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("no request credit came back in %s", test_name);
                report_failure();
            end
        end
    endtask

    task automatic send_req(input fv_addr_t addr, input fv_count_t num, input pe_tag_t tag);
        wait_credit();
        req_valid  = 1'b1;
        req_addr   = addr;
        req_num_fv = num;
        req_tag    = tag;
        pend_addr.push_back(addr);
        pend_num.push_back(num);
        pend_tag.push_back(tag);
        credits--;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_random(input int num_lo, input int num_hi);
        fv_addr_t  addr;
        fv_count_t num;
        addr = fv_addr_t'($urandom);
        num  = fv_count_t'(num_lo + $urandom % (num_hi - num_lo + 1));
        send_req(addr, num, pe_tag_t'($urandom));
    endtask

    // the controller must be idle on the first beat.
    task automatic write_burst(input fv_addr_t base, input int len);
        for (int k = 0; k < len; k++) begin
            wr_sos  = (k == 0);
            wr_eos  = (k == len - 1);
            wr_addr = fv_addr_t'(base + k);
            wr_data = {$urandom, $urandom};
            shadow[wr_addr] = wr_data;
            @(negedge clk);
        end
        wr_sos = 1'b0;
        wr_eos = 1'b0;
    endtask

    task automatic wait_quiet();
        int waited;
        waited = 0;
        while (pend_addr.size() != 0 || beat_idx != 0 || busy !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("outstanding reads did not drain in %s", test_name);
                report_failure();
            end
        end
    endtask

    initial begin
        fv_addr_t base;
        int       len;
        int       cycles;
        void'($urandom(32'h9f29_2b9c));
        reset      = 1'b1;
        wr_sos     = 1'b0;
        wr_eos     = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_num_fv = '0;
        req_tag    = '0;
        credits    = `FV_REQ_DEPTH;
        errors     = 0;
        beat_idx   = 0;
        exp_count  = 0;
        test_name  = "reset";
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset req_credit", 1'b0, req_credit);
        check_flag("reset busy", 1'b0, busy);

        test_name = "bank_fill";
        write_burst('0, `FV_BANK_DEPTH);

        test_name = "single_line";
        repeat (6) begin
            base = fv_addr_t'($urandom);
            len  = 1 + $urandom % 8;
            write_burst(base, len);
            send_req(fv_addr_t'(base + $urandom % len),
                     fv_count_t'(1 + $urandom % `FV_PER_LINE), pe_tag_t'($urandom));
            wait_quiet();
        end

        test_name = "multi_line";
        repeat (8) begin
            send_random(`FV_PER_LINE + 1, `FV_MAX_NUM);
            wait_quiet();
        end

        // counts that leave a partial last line.
        test_name = "partial_line";
        for (int i = 0; i < 8; i++) begin
            send_req(fv_addr_t'($urandom), fv_count_t'(4 * i + 1 + i % 3), pe_tag_t'($urandom));
        end
        wait_quiet();

        test_name = "credit_flow";
        repeat (`FV_REQ_DEPTH) send_random(1, `FV_MAX_NUM);
        wait_quiet();
        check_count(test_name, fv_count_t'(`FV_REQ_DEPTH), fv_count_t'(credits));
        repeat (16) send_random(1, `FV_MAX_NUM);
        wait_quiet();
        check_count(test_name, fv_count_t'(`FV_REQ_DEPTH), fv_count_t'(credits));

        // burst starts one cycle after the request, so it wins in idle.
        test_name = "write_over_queue";
        base = fv_addr_t'($urandom);
        send_req(base, fv_count_t'(`FV_MAX_NUM), pe_tag_t'($urandom));
        write_burst(base, 12);
        send_req(fv_addr_t'(base + 4), fv_count_t'(16), pe_tag_t'($urandom));
        wait_quiet();

        test_name = "first_beat_latency";
        send_random(1, `FV_MAX_NUM);
        cycles = 1;
        while (out_valid !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("first beat never arrived in %s", test_name);
                report_failure();
            end
        end
        check_count(test_name, fv_count_t'(3), fv_count_t'(cycles));
        check_flag("first_beat_latency sos", 1'b1, out_sos);
        wait_quiet();

        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire

// File: fv_bank.f
+incdir+.
fv_bank_pkg.sv
fv_sram_if.sv
fv_req_if.sv
fv_req_queue.sv
fv_bank_ctrl.sv
fv_sram.sv
fv_bank_top.sv
fv_bank_chk.sv
fv_bank_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module fv_bank_tb \
        -f fv_bank.f -o fv_bank_sim \
    && ./obj_dir/fv_bank_sim \
    || { echo "run_sim: build or run error" >&2; exit 1; }
